//--- include/tx_sched_defines.svh
// Transmit scheduler parameters
`ifndef TX_SCHED_DEFINES_SVH
`define TX_SCHED_DEFINES_SVH

// Queues and timeslots
`define TX_QUEUE_COUNT      8
`define TX_QUEUE_IDX_W      3
`define TDMA_SLOT_COUNT     4
`define TDMA_SLOT_IDX_W     2
`define TX_TAG_W            8

// Register interface
`define REG_ADDR_W          16
`define REG_DATA_W          32
`define REG_TYPE_VAL        32'h0000C060
`define REG_VER_VAL         32'h00000200

// Register byte offsets
`define REG_TYPE_ADDR       16'h0000
`define REG_VER_ADDR        16'h0004
`define REG_CTRL_ADDR       16'h0008
`define REG_START_ADDR      16'h0010
`define REG_SCHED_PER_ADDR  16'h0014
`define REG_SLOT_PER_ADDR   16'h0018
`define REG_ACTIVE_PER_ADDR 16'h001C
`define REG_SLOT_MASK_BASE  16'h0040 // One word per timslot mask

`endif

//--- hdl/tx_sched_pkg.sv
// Transmit scheduler types
`default_nettype none

`include "tx_sched_defines.svh"

package tx_sched_pkg;

    typedef logic [`TX_QUEUE_IDX_W-1:0] queue_idx_t;
    typedef logic [`TX_QUEUE_COUNT-1:0] queue_mask_t; // One bit per queue
    typedef logic [`TDMA_SLOT_IDX_W-1:0] slot_idx_t;
    typedef logic [`TX_TAG_W-1:0] tx_tag_t;
    typedef logic [31:0] ns_time_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`REG_DATA_W-1:0] reg_data_t;

    // Schedule timing, all in ns
    typedef struct packed {
        ns_time_t start;
        ns_time_t sched_per;
        ns_time_t slot_per;
        ns_time_t active_per;
    } tdma_cfg_t;

    typedef struct packed {
        logic      valid;  // Generator locked
        logic      active;
        slot_idx_t index;
    } tdma_slot_t;

    typedef struct packed {
        queue_idx_t queue;
        tx_tag_t    tag;
    } tx_req_t;

    typedef struct packed {
        queue_idx_t queue;
        logic       empty;
    } tx_status_t;

    typedef struct packed {
        logic        en;
        slot_idx_t   slot;
        queue_mask_t mask;
    } mask_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_START,
        RUN
    } tdma_state_t;

endpackage

`default_nettype wire

//--- hdl/tx_sched_regs.sv
// Scheduler control registers
`timescale 1ns/1ps
`default_nettype none

`include "tx_sched_defines.svh"

module tx_sched_regs (
    input  wire                            clk,
    input  wire                            rst,
    input  wire tx_sched_pkg::reg_addr_t   wr_addr,
    input  wire tx_sched_pkg::reg_data_t   wr_data,
    input  wire [`REG_DATA_W/8-1:0]        wr_strb,
    input  wire                            wr_en,
    output logic                           wr_ack,
    input  wire tx_sched_pkg::reg_addr_t   rd_addr,
    input  wire                            rd_en,
    output tx_sched_pkg::reg_data_t        rd_data,
    output logic                           rd_ack,
    input  wire tx_sched_pkg::tdma_slot_t  tdma_slot,
    output logic                           tdma_en,
    output tx_sched_pkg::tdma_cfg_t        tdma_cfg,
    output tx_sched_pkg::mask_wr_t         mask_wr
);
    import tx_sched_pkg::*;

    localparam reg_addr_t MASK_END = reg_addr_t'(`REG_SLOT_MASK_BASE + 4 * `TDMA_SLOT_COUNT);

    reg_addr_t   wr_word;
    reg_addr_t   rd_word;
    reg_addr_t   wr_mask_off;
    reg_addr_t   rd_mask_off;
    logic        wr_mask_hit;
    logic        rd_mask_hit;
    slot_idx_t   wr_mask_slot;
    slot_idx_t   rd_mask_slot;
    reg_data_t   ctrl_word;
    queue_mask_t mask_shadow [`TDMA_SLOT_COUNT]; // Readback copy of the table

    // Word aligned decode
    assign wr_word = {wr_addr[`REG_ADDR_W-1:2], 2'b00};
    assign rd_word = {rd_addr[`REG_ADDR_W-1:2], 2'b00};

    assign wr_mask_hit = (wr_word >= `REG_SLOT_MASK_BASE) && (wr_word < MASK_END);
    assign rd_mask_hit = (rd_word >= `REG_SLOT_MASK_BASE) && (rd_word < MASK_END);
    assign wr_mask_off = wr_word - `REG_SLOT_MASK_BASE;
    assign rd_mask_off = rd_word - `REG_SLOT_MASK_BASE;
    assign wr_mask_slot = wr_mask_off[`TDMA_SLOT_IDX_W+1:2];
    assign rd_mask_slot = rd_mask_off[`TDMA_SLOT_IDX_W+1:2];

    // Slot count, locked, enable
    assign ctrl_word = {16'(`TDMA_SLOT_COUNT), 7'b0, tdma_slot.valid, 7'b0, tdma_en};

    always_ff @(posedge clk) begin
        wr_ack     <= 1'b0;
        rd_ack     <= 1'b0;
        mask_wr.en <= 1'b0;

        if (wr_en && !wr_ack) begin
            wr_ack <= 1'b1;
            case (wr_word)
                `REG_TYPE_ADDR, `REG_VER_ADDR: ; // Read only
                `REG_CTRL_ADDR: begin
                    if (wr_strb[0]) begin
                        tdma_en <= wr_data[0];
                    end
                end
                `REG_START_ADDR:      tdma_cfg.start <= wr_data;
                `REG_SCHED_PER_ADDR:  tdma_cfg.sched_per <= wr_data;
                `REG_SLOT_PER_ADDR:   tdma_cfg.slot_per <= wr_data;
                `REG_ACTIVE_PER_ADDR: tdma_cfg.active_per <= wr_data;
                default: begin
                    if (wr_mask_hit) begin
                        mask_wr.en <= 1'b1;
                        mask_wr.slot <= wr_mask_slot;
                        mask_wr.mask <= wr_data[`TX_QUEUE_COUNT-1:0];
                        mask_shadow[wr_mask_slot] <= wr_data[`TX_QUEUE_COUNT-1:0];
                    end else begin
                        wr_ack <= 1'b0; // Unmapped
                    end
                end
            endcase
        end

        if (rd_en && !rd_ack) begin
            rd_ack <= 1'b1;
            case (rd_word)
                `REG_TYPE_ADDR:       rd_data <= `REG_TYPE_VAL;
                `REG_VER_ADDR:        rd_data <= `REG_VER_VAL;
                `REG_CTRL_ADDR:       rd_data <= ctrl_word;
                `REG_START_ADDR:      rd_data <= tdma_cfg.start;
                `REG_SCHED_PER_ADDR:  rd_data <= tdma_cfg.sched_per;
                `REG_SLOT_PER_ADDR:   rd_data <= tdma_cfg.slot_per;
                `REG_ACTIVE_PER_ADDR: rd_data <= tdma_cfg.active_per;
                default: begin
                    if (rd_mask_hit) begin
                        rd_data <= reg_data_t'(mask_shadow[rd_mask_slot]);
                    end else begin
                        rd_ack <= 1'b0;
                    end
                end
            endcase
        end

        if (rst) begin
            wr_ack     <= 1'b0;
            rd_ack     <= 1'b0;
            mask_wr.en <= 1'b0;
            tdma_en    <= 1'b0;
            tdma_cfg   <= '0;
            for (int i = 0; i < `TDMA_SLOT_COUNT; i++) begin
                mask_shadow[i] <= '0;
            end
        end
    end

    // Host drops wr_en on the ack, so acks never run back to back
    assert property (@(posedge clk) disable iff (rst) wr_ack |=> !wr_ack)
        else $error("wr_ack high on two consecutive cycles");

endmodule

`default_nettype wire

//--- hdl/tdma_timeslot_gen.sv
// TDMA timeslot generator
`timescale 1ns/1ps
`default_nettype none

`include "tx_sched_defines.svh"

module tdma_timeslot_gen (
    input  wire                           clk,
    input  wire                           rst,
    input  wire tx_sched_pkg::ns_time_t   ts_ns,
    input  wire                           tdma_en,
    input  wire tx_sched_pkg::tdma_cfg_t  tdma_cfg,
    output tx_sched_pkg::tdma_slot_t      tdma_slot
);
    import tx_sched_pkg::*;

    localparam int CNT_W = `TDMA_SLOT_IDX_W + 1;
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`TDMA_SLOT_COUNT);

    tdma_state_t      state;
    ns_time_t         sched_base;
    ns_time_t         slot_base;
    logic [CNT_W-1:0] slot_cnt;  // Saturates past the last slot

    ns_time_t         start_off;
    ns_time_t         sched_off;
    ns_time_t         slot_off;
    ns_time_t         next_off;
    ns_time_t         next_sched_base;
    ns_time_t         next_slot_base;
    logic [CNT_W-1:0] next_cnt;
    logic             next_active;
    logic             start_reached;

    assign start_off = ts_ns - tdma_cfg.start;
    assign start_reached = !start_off[31]; // Wrap-safe compare
    assign sched_off = ts_ns - sched_base;
    assign slot_off = ts_ns - slot_base;

    // Advance bases for the sampled time
    always_comb begin
        next_sched_base = sched_base;
        next_slot_base  = slot_base;
        next_cnt        = slot_cnt;
        if (sched_off >= tdma_cfg.sched_per) begin
            next_sched_base = sched_base + tdma_cfg.sched_per;
            next_slot_base  = sched_base + tdma_cfg.sched_per;
            next_cnt        = '0;
        end else if (slot_off >= tdma_cfg.slot_per) begin
            next_slot_base = slot_base + tdma_cfg.slot_per;
            if (slot_cnt != CNT_MAX) begin
                next_cnt = slot_cnt + 1'b1;
            end
        end
    end

    assign next_off = ts_ns - next_slot_base;
    assign next_active = (next_off < tdma_cfg.active_per) && (next_cnt < CNT_MAX);

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (tdma_en) begin
                    state <= WAIT_START;
                end
            end
            WAIT_START: begin
                if (!tdma_en) begin
                    state <= IDLE;
                end else if (start_reached) begin
                    state            <= RUN;
                    sched_base       <= tdma_cfg.start;
                    slot_base        <= tdma_cfg.start;
                    slot_cnt         <= '0;
                    tdma_slot.valid  <= 1'b1;
                    tdma_slot.active <= start_off < tdma_cfg.active_per;
                    tdma_slot.index  <= '0;
                end
            end
            RUN: begin
                if (!tdma_en) begin
                    state            <= IDLE;
                    tdma_slot.valid  <= 1'b0;
                    tdma_slot.active <= 1'b0;
                end else begin
                    sched_base       <= next_sched_base;
                    slot_base        <= next_slot_base;
                    slot_cnt         <= next_cnt;
                    tdma_slot.active <= next_active;
                    tdma_slot.index  <= next_cnt[`TDMA_SLOT_IDX_W-1:0];
                end
            end
            default: state <= IDLE;
        endcase

        if (rst) begin
            state     <= IDLE;
            tdma_slot <= '0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) tdma_slot.active |-> tdma_slot.valid)
        else $error("Timeslot active while generator not locked");

endmodule

`default_nettype wire

//--- hdl/slot_enable_table.sv
// Per-timeslot queue enable table
`timescale 1ns/1ps
`default_nettype none

`include "tx_sched_defines.svh"

module slot_enable_table (
    input  wire                           clk,
    input  wire                           rst,
    input  wire tx_sched_pkg::mask_wr_t   mask_wr,
    input  wire tx_sched_pkg::tdma_slot_t tdma_slot,
    output tx_sched_pkg::queue_mask_t     slot_mask
);
    import tx_sched_pkg::*;

    queue_mask_t mask_mem [`TDMA_SLOT_COUNT];
    logic        slot_on;

    assign slot_on = tdma_slot.valid && tdma_slot.active;

    always_ff @(posedge clk) begin
        if (mask_wr.en) begin
            mask_mem[mask_wr.slot] <= mask_wr.mask;
        end

        slot_mask <= slot_on ? mask_mem[tdma_slot.index] : '0; // Lookup for current slot

        if (rst) begin
            slot_mask <= '0;
            for (int i = 0; i < `TDMA_SLOT_COUNT; i++) begin
                mask_mem[i] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/rr_queue_arbiter.sv
// Round-robin transmit request arbiter
`timescale 1ns/1ps
`default_nettype none

`include "tx_sched_defines.svh"

module rr_queue_arbiter (
    input  wire                            clk,
    input  wire                            rst,
    input  wire tx_sched_pkg::queue_idx_t  doorbell_queue,
    input  wire                            doorbell_valid,
    input  wire tx_sched_pkg::tx_status_t  status,
    input  wire                            status_valid,
    input  wire tx_sched_pkg::queue_mask_t slot_mask,
    output tx_sched_pkg::tx_req_t          tx_req,
    output logic                           tx_req_valid,
    input  wire                            tx_req_ready
);
    import tx_sched_pkg::*;

    queue_mask_t pending;
    queue_mask_t inflight;
    queue_mask_t eligible;
    queue_idx_t  last_grant;
    queue_idx_t  search_base;
    queue_idx_t  cand;
    queue_idx_t  sel_queue;
    logic        sel_found;
    tx_tag_t     tag_cnt;
    tx_tag_t     tag_next;
    logic        handshake;
    logic        can_select;

    assign handshake = tx_req_valid && tx_req_ready;
    assign can_select = !tx_req_valid || handshake; // Nothing held after this cycle
    assign search_base = handshake ? tx_req.queue : last_grant;
    assign tag_next = handshake ? tag_cnt + 1'b1 : tag_cnt;

    always_comb begin
        eligible = pending & ~inflight & slot_mask;
        if (handshake) begin
            eligible[tx_req.queue] = 1'b0; // In flight from next cycle
        end
    end

    // First eligible queue after the last grant, wrapping
    always_comb begin
        sel_found = 1'b0;
        sel_queue = search_base;
        cand      = search_base;
        for (int i = 1; i <= `TX_QUEUE_COUNT; i++) begin
            cand = search_base + queue_idx_t'(i);
            if (!sel_found && eligible[cand]) begin
                sel_found = 1'b1;
                sel_queue = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (status_valid) begin
            inflight[status.queue] <= 1'b0;
            if (status.empty) begin
                pending[status.queue] <= 1'b0;
            end
        end
        if (doorbell_valid) begin
            pending[doorbell_queue] <= 1'b1; // Wins over empty status
        end
        if (handshake) begin
            inflight[tx_req.queue] <= 1'b1;
            last_grant <= tx_req.queue;
        end

        tag_cnt <= tag_next;

        if (can_select) begin
            tx_req_valid <= sel_found;
            if (sel_found) begin
                tx_req.queue <= sel_queue;
                tx_req.tag   <= tag_next;
            end
        end

        if (rst) begin
            pending      <= '0;
            inflight     <= '0;
            last_grant   <= '1; // First search starts at queue 0
            tag_cnt      <= '0;
            tx_req_valid <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        tx_req_valid && !tx_req_ready |=> tx_req_valid && $stable(tx_req))
        else $error("tx_req changed under back-pressure");

endmodule

`default_nettype wire

//--- hdl/tx_sched_block.sv
// Transmit scheduler top level
`timescale 1ns/1ps
`default_nettype none

`include "tx_sched_defines.svh"

module tx_sched_block (
    input  wire                            clk,
    input  wire                            rst,
    input  wire tx_sched_pkg::reg_addr_t   wr_addr,
    input  wire tx_sched_pkg::reg_data_t   wr_data,
    input  wire [`REG_DATA_W/8-1:0]        wr_strb,
    input  wire                            wr_en,
    output logic                           wr_ack,
    input  wire tx_sched_pkg::reg_addr_t   rd_addr,
    input  wire                            rd_en,
    output tx_sched_pkg::reg_data_t        rd_data,
    output logic                           rd_ack,
    input  wire tx_sched_pkg::ns_time_t    ts_ns,
    input  wire tx_sched_pkg::queue_idx_t  doorbell_queue,
    input  wire                            doorbell_valid,
    input  wire tx_sched_pkg::tx_status_t  status,
    input  wire                            status_valid,
    output tx_sched_pkg::tx_req_t          tx_req,
    output logic                           tx_req_valid,
    input  wire                            tx_req_ready
);
    import tx_sched_pkg::*;

    logic        tdma_en;
    tdma_cfg_t   tdma_cfg;
    mask_wr_t    mask_wr;
    tdma_slot_t  tdma_slot;
    queue_mask_t slot_mask;

    tx_sched_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_strb   (wr_strb),
        .wr_en     (wr_en),
        .wr_ack    (wr_ack),
        .rd_addr   (rd_addr),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .rd_ack    (rd_ack),
        .tdma_slot (tdma_slot),
        .tdma_en   (tdma_en),
        .tdma_cfg  (tdma_cfg),
        .mask_wr   (mask_wr)
    );

    tdma_timeslot_gen u_timeslot_gen (
        .clk       (clk),
        .rst       (rst),
        .ts_ns     (ts_ns),
        .tdma_en   (tdma_en),
        .tdma_cfg  (tdma_cfg),
        .tdma_slot (tdma_slot)
    );

    // Mask lookup one cycle behind the slot
    slot_enable_table u_slot_table (
        .clk       (clk),
        .rst       (rst),
        .mask_wr   (mask_wr),
        .tdma_slot (tdma_slot),
        .slot_mask (slot_mask)
    );

    rr_queue_arbiter u_arbiter (
        .clk            (clk),
        .rst            (rst),
        .doorbell_queue (doorbell_queue),
        .doorbell_valid (doorbell_valid),
        .status         (status),
        .status_valid   (status_valid),
        .slot_mask      (slot_mask),
        .tx_req         (tx_req),
        .tx_req_valid   (tx_req_valid),
        .tx_req_ready   (tx_req_ready)
    );

endmodule

`default_nettype wire

//--- verif/tb_tx_sched_block.sv
// Transmit scheduler testbench
`timescale 1ns/1ps
`default_nettype none

`include "tx_sched_defines.svh"

module tb_tx_sched_block;
    import tx_sched_pkg::*;

    localparam int       CYCLE_LIMIT = 20000;
    localparam int       ACK_WAIT = 16;
    localparam int       REQ_WAIT = 400;
    localparam ns_time_t SCHED_PER = 32'd800;
    localparam ns_time_t SLOT_PER = 32'd200;

    logic                     clk;
    logic                     rst;
    reg_addr_t                wr_addr;
    reg_data_t                wr_data;
    logic [`REG_DATA_W/8-1:0] wr_strb;
    logic                     wr_en;
    logic                     wr_ack;
    reg_addr_t                rd_addr;
    logic                     rd_en;
    reg_data_t                rd_data;
    logic                     rd_ack;
    ns_time_t                 ts_ns;
    queue_idx_t               doorbell_queue;
    logic                     doorbell_valid;
    tx_status_t               status;
    logic                     status_valid;
    tx_req_t                  tx_req;
    logic                     tx_req_valid;
    logic                     tx_req_ready;

    ns_time_t ts_d1;
    ns_time_t ts_d2;
    ns_time_t ts_d3;    // Time seen by the generator three edges back
    ns_time_t req_ts;   // Time behind the newest request
    logic     valid_q;
    logic     hs_q;
    int       cycle_cnt;
    ns_time_t sched_start;
    int       last_queue;
    ns_time_t last_ts;

    tx_sched_block DUT (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Time base, request time tracking and run limit
    always @(posedge clk) begin
        ts_ns <= ts_ns + 32'd8;
        ts_d1 <= ts_ns;
        ts_d2 <= ts_d1;
        ts_d3 <= ts_d2;
        if (tx_req_valid && (!valid_q || hs_q)) begin
            req_ts <= ts_d3;
        end
        valid_q <= tx_req_valid;
        hs_q <= tx_req_valid && tx_req_ready;
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            stop_run("Run stopped at the cycle limit before the tests finished");
        end
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        if (actual !== expected) begin
            $display("Error at time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data,
                             input logic [3:0] strb, input logic expect_ack);
        int   wait_cnt;
        logic acked;
        @(posedge clk);
        wr_addr <= addr;
        wr_data <= data;
        wr_strb <= strb;
        wr_en   <= 1'b1;
        wait_cnt = 0;
        acked = 1'b0;
        while (!acked && wait_cnt < ACK_WAIT) begin
            @(posedge clk);
            wait_cnt++;
            acked = wr_ack;
        end
        wr_en <= 1'b0;
        if (expect_ack && !acked) begin
            stop_run($sformatf("Register write to 0x%0h got no ack within 16 cycles", addr));
        end else if (!expect_ack && acked) begin
            stop_run($sformatf("Register write to unmapped 0x%0h was acknowledged", addr));
        end
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_data_t data,
                            input logic expect_ack);
        int   wait_cnt;
        logic acked;
        @(posedge clk);
        rd_addr <= addr;
        rd_en   <= 1'b1;
        wait_cnt = 0;
        acked = 1'b0;
        while (!acked && wait_cnt < ACK_WAIT) begin
            @(posedge clk);
            wait_cnt++;
            acked = rd_ack;
        end
        data = rd_data; // Valid with rd_ack
        rd_en <= 1'b0;
        if (expect_ack && !acked) begin
            stop_run($sformatf("Register read from 0x%0h got no ack within 16 cycles", addr));
        end else if (!expect_ack && acked) begin
            stop_run($sformatf("Register read from unmapped 0x%0h was acknowledged", addr));
        end
    endtask

    task automatic ring_doorbell(input queue_idx_t queue);
        @(posedge clk);
        doorbell_queue <= queue;
        doorbell_valid <= 1'b1;
        @(posedge clk);
        doorbell_valid <= 1'b0;
    endtask

    task automatic send_status(input queue_idx_t queue, input logic empty);
        @(posedge clk);
        status.queue <= queue;
        status.empty <= empty;
        status_valid <= 1'b1;
        @(posedge clk);
        status_valid <= 1'b0;
    endtask

    // Waits for a request, stalls it, then takes it; exp_queue < 0 accepts any queue
    task automatic expect_request(input int exp_queue, input int exp_tag, input int hold_cycles);
        int      wait_cnt;
        int      i;
        tx_req_t held;
        wait_cnt = 0;
        do begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > REQ_WAIT) begin
                stop_run("No transmit request arrived within 400 cycles");
            end
        end while (!tx_req_valid);
        held = tx_req;
        for (i = 0; i < hold_cycles; i++) begin
            @(posedge clk);
            compare_value(tx_req_valid, 1'b1, "request valid dropped while stalled");
            compare_value(tx_req, held, "request changed while stalled");
        end
        tx_req_ready <= 1'b1;
        @(posedge clk);
        tx_req_ready <= 1'b0;
        compare_value(tx_req_valid, 1'b1, "request valid at handshake");
        compare_value(tx_req, held, "request changed before handshake");
        if (exp_queue >= 0) begin
            compare_value(tx_req.queue, exp_queue, "request queue");
        end
        compare_value(tx_req.tag, exp_tag, "request tag");
        last_queue = tx_req.queue;
        last_ts = req_ts;
    endtask

    task automatic start_schedule(input ns_time_t active_per);
        reg_write(`REG_SCHED_PER_ADDR, SCHED_PER, 4'hF, 1'b1);
        reg_write(`REG_SLOT_PER_ADDR, SLOT_PER, 4'hF, 1'b1);
        reg_write(`REG_ACTIVE_PER_ADDR, active_per, 4'hF, 1'b1);
        sched_start = ts_ns + 32'd200; // A few cycles ahead
        reg_write(`REG_START_ADDR, sched_start, 4'hF, 1'b1);
        reg_write(`REG_CTRL_ADDR, 32'h1, 4'h1, 1'b1);
    endtask

    task automatic write_masks(input queue_mask_t m0, input queue_mask_t m1,
                               input queue_mask_t m2, input queue_mask_t m3);
        reg_write(`REG_SLOT_MASK_BASE, {24'hFFFFFF, m0}, 4'hF, 1'b1);
        reg_write(`REG_SLOT_MASK_BASE + 16'h4, {24'hFFFFFF, m1}, 4'hF, 1'b1);
        reg_write(`REG_SLOT_MASK_BASE + 16'h8, {24'hFFFFFF, m2}, 4'hF, 1'b1);
        reg_write(`REG_SLOT_MASK_BASE + 16'hC, {24'hFFFFFF, m3}, 4'hF, 1'b1);
    endtask

    task automatic check_register_map();
        reg_data_t rdata;
        int        i;
        reg_read(`REG_TYPE_ADDR, rdata, 1'b1);
        compare_value(rdata, `REG_TYPE_VAL, "type register");
        reg_read(`REG_VER_ADDR, rdata, 1'b1);
        compare_value(rdata, `REG_VER_VAL, "version register");
        reg_read(`REG_CTRL_ADDR, rdata, 1'b1);
        compare_value(rdata[31:16], `TDMA_SLOT_COUNT, "timeslot count in control");
        for (i = 0; i < 4; i++) begin
            reg_write(`REG_START_ADDR + 16'(4 * i), 32'h5A00_1000 ^ (32'h0101_0101 << i),
                      4'hF, 1'b1);
        end
        for (i = 0; i < 4; i++) begin
            reg_read(`REG_START_ADDR + 16'(4 * i), rdata, 1'b1);
            compare_value(rdata, 32'h5A00_1000 ^ (32'h0101_0101 << i), "timing register");
        end
        write_masks(8'h1B, 8'h3D, 8'h5F, 8'h81);
        for (i = 0; i < 4; i++) begin
            reg_read(`REG_SLOT_MASK_BASE + 16'(4 * i), rdata, 1'b1);
            compare_value(rdata, 32'h1B + 32'h22 * i, "slot mask readback");
        end
        reg_write(16'h0030, 32'hDEAD_BEEF, 4'hF, 1'b0);
        reg_read(16'h0030, rdata, 1'b0);
    endtask

    task automatic check_lock_status();
        reg_data_t rdata;
        reg_write(`REG_CTRL_ADDR, 32'h1, 4'hE, 1'b1); // Strobe bit 0 clear
        reg_read(`REG_CTRL_ADDR, rdata, 1'b1);
        compare_value(rdata[0], 1'b0, "enable written without its strobe");
        start_schedule(SLOT_PER);
        reg_read(`REG_CTRL_ADDR, rdata, 1'b1);
        compare_value(rdata[8], 1'b0, "locked before the schedule start");
        compare_value(rdata[0], 1'b1, "enable readback");
        while (ts_ns < sched_start + 32'd16) begin
            @(posedge clk);
        end
        reg_read(`REG_CTRL_ADDR, rdata, 1'b1);
        compare_value(rdata[8], 1'b1, "locked after the schedule start");
        reg_write(`REG_CTRL_ADDR, 32'h0, 4'h1, 1'b1);
        reg_read(`REG_CTRL_ADDR, rdata, 1'b1);
        compare_value(rdata[8], 1'b0, "locked after disable");
    endtask

    task automatic run_round_robin();
        write_masks(8'hFF, 8'hFF, 8'hFF, 8'hFF);
        start_schedule(SLOT_PER); // Always active
        ring_doorbell(3'd1);
        ring_doorbell(3'd3);
        ring_doorbell(3'd5);
        expect_request(1, 0, 0);
        expect_request(3, 1, 0);
        expect_request(5, 2, 0);
        send_status(3'd1, 1'b0);
        send_status(3'd3, 1'b0);
        send_status(3'd5, 1'b0);
        expect_request(1, 3, 0);
        expect_request(3, 4, 0);
        expect_request(5, 5, 0);
    endtask

    task automatic check_slot_gating();
        ns_time_t    offset;
        queue_mask_t seen;
        int          n;
        seen = '0;
        write_masks(8'h04, 8'h40, 8'h00, 8'h00);
        reg_write(`REG_ACTIVE_PER_ADDR, 32'd150, 4'hF, 1'b1);
        ring_doorbell(3'd2);
        ring_doorbell(3'd6);
        for (n = 0; n < 2; n++) begin
            expect_request(-1, 6 + n, 0);
            offset = (last_ts - sched_start) % SCHED_PER;
            compare_value((offset % SLOT_PER) < 32'd150, 1'b1, "request outside active window");
            if (last_queue == 2) begin
                compare_value(offset / SLOT_PER, 0, "timeslot of queue 2 request");
            end else begin
                compare_value(last_queue, 6, "queue not enabled in any slot");
                compare_value(offset / SLOT_PER, 1, "timeslot of queue 6 request");
            end
            seen[last_queue] = 1'b1;
        end
        compare_value(seen, 8'h44, "queues requested under slot masks");
    endtask

    task automatic hold_back_pressure();
        write_masks(8'hFF, 8'hFF, 8'hFF, 8'hFF);
        reg_write(`REG_ACTIVE_PER_ADDR, SLOT_PER, 4'hF, 1'b1);
        send_status(3'd2, 1'b0);
        send_status(3'd6, 1'b0);
        expect_request(2, 8, 10);
        expect_request(6, 9, 0);
    endtask

    task automatic drain_empty_queue();
        int n;
        send_status(3'd3, 1'b1);
        send_status(3'd1, 1'b0);
        send_status(3'd5, 1'b0);
        for (n = 0; n < 4; n++) begin
            expect_request((n % 2 == 1) ? 5 : 1, 10 + n, 0);
            send_status(queue_idx_t'(last_queue), 1'b0);
        end
        ring_doorbell(3'd3); // Queue 3 comes back only now
        expect_request(1, 14, 0);
        expect_request(3, 15, 0);
    endtask

    initial begin
        rst            = 1'b1;
        ts_ns          = '0;
        wr_addr        = '0;
        wr_data        = '0;
        wr_strb        = '0;
        wr_en          = 1'b0;
        rd_addr        = '0;
        rd_en          = 1'b0;
        doorbell_queue = '0;
        doorbell_valid = 1'b0;
        status         = '0;
        status_valid   = 1'b0;
        tx_req_ready   = 1'b0;
        ts_d1          = '0;
        ts_d2          = '0;
        ts_d3          = '0;
        req_ts         = '0;
        valid_q        = 1'b0;
        hs_q           = 1'b0;
        cycle_cnt      = 0;
        sched_start    = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        check_register_map();
        check_lock_status();
        run_round_robin();
        check_slot_gating();
        hold_back_pressure();
        drain_empty_queue();
        repeat (4) @(posedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
hdl/tx_sched_pkg.sv
hdl/tx_sched_regs.sv
hdl/tdma_timeslot_gen.sv
hdl/slot_enable_table.sv
hdl/rr_queue_arbiter.sv
hdl/tx_sched_block.sv
verif/tb_tx_sched_block.sv

//--- Bender.yml
package:
  name: tx_sched

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/tx_sched_pkg.sv
      - hdl/tx_sched_regs.sv
      - hdl/tdma_timeslot_gen.sv
      - hdl/slot_enable_table.sv
      - hdl/rr_queue_arbiter.sv
      - hdl/tx_sched_block.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_tx_sched_block.sv
